//--- build.f
+incdir+test
hw/scu_dsp_pkg.sv
hw/dsp_alu.sv
hw/dsp_data_bank.sv
hw/dsp_decoder.sv
hw/dsp_datapath.sv
hw/scu_dsp_top.sv
test/tb_scu_dsp.sv

//--- hw/dsp_alu.sv
module dsp_alu (
	input scu_dsp_pkg::acc_t a,	// ACH:ACL
	input scu_dsp_pkg::acc_t b,	// PH:PL
	input scu_dsp_pkg::alu_op_e op,
	input scu_dsp_pkg::dsp_flags_t flags_in,
	output scu_dsp_pkg::acc_t result,
	output scu_dsp_pkg::dsp_flags_t flags_out
);

	scu_dsp_pkg::word_t a_l;
	scu_dsp_pkg::word_t b_l;
	scu_dsp_pkg::word_t res32;
	logic [scu_dsp_pkg::WORD_W:0] sum_n;	// Extra bit is the carry
	logic [scu_dsp_pkg::WORD_W:0] diff_n;	// Extra bit is the borrow
	logic [scu_dsp_pkg::ACC_W:0] sum_w;
	logic c_new;
	logic v_new;
	logic wide;
	logic keep;

	assign a_l = a[scu_dsp_pkg::WORD_W-1:0];
	assign b_l = b[scu_dsp_pkg::WORD_W-1:0];
	assign sum_n = {1'b0, a_l} + {1'b0, b_l};
	assign diff_n = {1'b0, a_l} - {1'b0, b_l};
	assign sum_w = {1'b0, a} + {1'b0, b};

	always_comb begin
		res32 = a_l;
		c_new = flags_in.c;
		v_new = flags_in.v;
		wide = 1'b0;
		keep = 1'b0;
		case (op)
			scu_dsp_pkg::ALU_AND: begin
				res32 = a_l & b_l;
				c_new = 1'b0;
			end
			scu_dsp_pkg::ALU_OR: begin
				res32 = a_l | b_l;
				c_new = 1'b0;
			end
			scu_dsp_pkg::ALU_XOR: begin
				res32 = a_l ^ b_l;
				c_new = 1'b0;
			end
			scu_dsp_pkg::ALU_ADD: begin
				res32 = sum_n[31:0];
				c_new = sum_n[32];
				v_new = (a_l[31] == b_l[31]) && (sum_n[31] != a_l[31]);
			end
			scu_dsp_pkg::ALU_SUB: begin
				res32 = diff_n[31:0];
				c_new = diff_n[32];
				v_new = (a_l[31] != b_l[31]) && (diff_n[31] != a_l[31]);
			end
			scu_dsp_pkg::ALU_AD2: begin
				wide = 1'b1;
				c_new = sum_w[48];
				v_new = (a[47] == b[47]) && (sum_w[47] != a[47]);
			end
			scu_dsp_pkg::ALU_SR: begin
				res32 = {a_l[31], a_l[31:1]};	// Sign bit held
				c_new = a_l[0];
			end
			scu_dsp_pkg::ALU_RR: begin
				res32 = {a_l[0], a_l[31:1]};
				c_new = a_l[0];
			end
			scu_dsp_pkg::ALU_SL: begin
				res32 = {a_l[30:0], 1'b0};
				c_new = a_l[31];
			end
			scu_dsp_pkg::ALU_RL: begin
				res32 = {a_l[30:0], a_l[31]};
				c_new = a_l[31];
			end
			scu_dsp_pkg::ALU_RL8: begin
				res32 = {a_l[23:0], a_l[31:24]};
				c_new = a_l[24];
			end
			default: keep = 1'b1;	// NOP and the spare codes
		endcase

		if (keep) begin
			result = a;
			flags_out = flags_in;
		end else if (wide) begin
			result = sum_w[scu_dsp_pkg::ACC_W-1:0];
			flags_out.s = sum_w[47];
			flags_out.z = (sum_w[scu_dsp_pkg::ACC_W-1:0] == '0);
			flags_out.c = c_new;
			flags_out.v = v_new;
		end else begin
			result = scu_dsp_pkg::acc_t'(res32);	// ACH forced to zero
			flags_out.s = res32[31];
			flags_out.z = (res32 == '0);
			flags_out.c = c_new;
			flags_out.v = v_new;
		end
	end

endmodule

//--- hw/dsp_data_bank.sv
module dsp_data_bank (
	input logic CLOCK,
	input logic rst,
	input scu_dsp_pkg::dsp_bank_ctrl_t bank_ctrl,
	input scu_dsp_pkg::word_t d1,
	output scu_dsp_pkg::word_t dout
);

	scu_dsp_pkg::word_t mem [2**scu_dsp_pkg::CT_W];
	scu_dsp_pkg::ct_t ct;	// CTn address counter

	// Read at the current counter, old word on a same-cycle write
	assign dout = mem[ct];

	always_ff @(posedge CLOCK) begin
		if (bank_ctrl.md_wr) begin
			mem[ct] <= d1;
		end
	end

	always_ff @(posedge CLOCK) begin
		if (rst) begin
			ct <= '0;
		end else if (bank_ctrl.ct_load) begin
			ct <= d1[scu_dsp_pkg::CT_W-1:0];	// Load beats increment
		end else if (bank_ctrl.ct_inc) begin
			ct <= ct + 1'b1;	// Wraps 63 to 0
		end
	end

	// A write to MDn and a load of CTn come from the same D1 destination code
	wr_not_with_load: assert property (@(posedge CLOCK) disable iff (rst)
		!(bank_ctrl.md_wr && bank_ctrl.ct_load));

endmodule

//--- hw/dsp_datapath.sv
module dsp_datapath (
	input logic CLOCK,
	input logic rst,
	input scu_dsp_pkg::dsp_ctrl_t ctrl,
	input scu_dsp_pkg::word_t md_dout [scu_dsp_pkg::NUM_BANKS],
	output scu_dsp_pkg::word_t d1,
	output scu_dsp_pkg::acc_t acc,
	output scu_dsp_pkg::acc_t prod,
	output scu_dsp_pkg::dsp_flags_t flags
);

	scu_dsp_pkg::word_t x_bus;
	scu_dsp_pkg::word_t y_bus;
	scu_dsp_pkg::word_t rx_q;
	scu_dsp_pkg::word_t ry_q;
	scu_dsp_pkg::acc_t p_q;	// PH:PL
	scu_dsp_pkg::acc_t a_q;	// ACH:ACL
	scu_dsp_pkg::acc_t alu_res;
	scu_dsp_pkg::dsp_flags_t flags_q;
	scu_dsp_pkg::dsp_flags_t alu_flags;
	logic signed [2*scu_dsp_pkg::WORD_W-1:0] mul_full;

	assign x_bus = md_dout[ctrl.x_bank];
	assign y_bus = md_dout[ctrl.y_bank];

	always_comb begin
		case (ctrl.d1_src)
			scu_dsp_pkg::D1_IMM: d1 = scu_dsp_pkg::word_t'(ctrl.imm);	// Zero-extended
			scu_dsp_pkg::D1_MD: d1 = md_dout[ctrl.d1_bank];
			scu_dsp_pkg::D1_ACL: d1 = a_q[scu_dsp_pkg::WORD_W-1:0];
			scu_dsp_pkg::D1_ACH: d1 = scu_dsp_pkg::word_t'(a_q[scu_dsp_pkg::ACC_W-1:scu_dsp_pkg::WORD_W]);
			default: d1 = '0;
		endcase
	end

	// Uses RX and RY as left by earlier instructions
	assign mul_full = $signed(rx_q) * $signed(ry_q);

	always_ff @(posedge CLOCK) begin
		if (rst) begin
			rx_q <= '0;
			ry_q <= '0;
		end else begin
			if (ctrl.rx_load) begin
				rx_q <= ctrl.rx_from_d1 ? d1 : x_bus;
			end
			if (ctrl.ry_load) begin
				ry_q <= y_bus;
			end
		end
	end

	always_ff @(posedge CLOCK) begin
		if (rst) begin
			p_q <= '0;
		end else if (ctrl.pl_from_d1) begin
			p_q <= scu_dsp_pkg::acc_t'(d1);	// PH cleared
		end else if (ctrl.pl_from_x) begin
			p_q <= scu_dsp_pkg::acc_t'(x_bus);
		end else if (ctrl.mul_to_p) begin
			p_q <= mul_full[scu_dsp_pkg::ACC_W-1:0];	// Low 48 bits kept
		end
	end

	always_ff @(posedge CLOCK) begin
		if (rst) begin
			a_q <= '0;
			flags_q <= '0;
		end else if (ctrl.clr_a) begin
			a_q <= '0;
		end else if (ctrl.alu_to_a) begin
			a_q <= alu_res;
			flags_q <= alu_flags;	// Flags follow the ALU write only
		end else if (ctrl.acl_from_y) begin
			a_q <= scu_dsp_pkg::acc_t'(y_bus);	// ACH cleared
		end
	end

	dsp_alu u_alu (
		.a(a_q),
		.b(p_q),
		.op(ctrl.alu_op),
		.flags_in(flags_q),
		.result(alu_res),
		.flags_out(alu_flags)
	);

	assign acc = a_q;
	assign prod = p_q;
	assign flags = flags_q;

endmodule

//--- hw/dsp_decoder.sv
module dsp_decoder (
	input logic CLOCK,
	input logic rst,
	input logic inst_valid,
	input scu_dsp_pkg::word_t inst,
	output scu_dsp_pkg::dsp_ctrl_t ctrl
);

	logic valid_q;
	scu_dsp_pkg::word_t inst_q;	// Fetch register

	logic [1:0] cls;
	logic [2:0] x_op;
	logic [2:0] y_op;
	logic [1:0] d1_op;
	logic [3:0] d1_dst;
	logic [3:0] src_code;
	logic x_inc;
	logic y_inc;
	scu_dsp_pkg::bank_sel_t x_bank;
	scu_dsp_pkg::bank_sel_t y_bank;

	always_ff @(posedge CLOCK) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= inst_valid;	// Idle cycle fetches a bubble
		end
	end

	always_ff @(posedge CLOCK) begin
		inst_q <= inst;
	end

	assign cls = inst_q[scu_dsp_pkg::CLS_HI:scu_dsp_pkg::CLS_LO];
	assign x_op = inst_q[scu_dsp_pkg::X_OP_HI:scu_dsp_pkg::X_OP_LO];
	assign x_inc = inst_q[scu_dsp_pkg::X_INC];
	assign x_bank = inst_q[scu_dsp_pkg::X_BANK_HI:scu_dsp_pkg::X_BANK_LO];
	assign y_op = inst_q[scu_dsp_pkg::Y_OP_HI:scu_dsp_pkg::Y_OP_LO];
	assign y_inc = inst_q[scu_dsp_pkg::Y_INC];
	assign y_bank = inst_q[scu_dsp_pkg::Y_BANK_HI:scu_dsp_pkg::Y_BANK_LO];
	assign d1_op = inst_q[scu_dsp_pkg::D1_OP_HI:scu_dsp_pkg::D1_OP_LO];
	assign d1_dst = inst_q[scu_dsp_pkg::D1_DST_HI:scu_dsp_pkg::D1_DST_LO];
	assign src_code = inst_q[scu_dsp_pkg::D1_SRC_LO +: 4];

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = scu_dsp_pkg::ALU_NOP;
		ctrl.d1_src = scu_dsp_pkg::D1_NONE;
		ctrl.x_bank = x_bank;
		ctrl.y_bank = y_bank;
		ctrl.d1_bank = src_code[1:0];
		ctrl.imm = inst_q[scu_dsp_pkg::D1_SRC_HI:scu_dsp_pkg::D1_SRC_LO];
		if (valid_q && cls == scu_dsp_pkg::CLS_OPERATION) begin
			ctrl.alu_op = scu_dsp_pkg::alu_op_e'(inst_q[scu_dsp_pkg::ALU_HI:scu_dsp_pkg::ALU_LO]);

			case (x_op)
				3'b100: ctrl.rx_load = 1'b1;	// MOV [s],X
				3'b010: ctrl.mul_to_p = 1'b1;	// MOV MUL,P
				3'b011: ctrl.pl_from_x = 1'b1;	// MOV [s],P
				default: ;
			endcase
			if (x_inc && (x_op == 3'b100 || x_op == 3'b011)) begin
				ctrl.bank[x_bank].ct_inc = 1'b1;
			end

			case (y_op)
				3'b100: ctrl.ry_load = 1'b1;	// MOV [s],Y
				3'b001: ctrl.clr_a = 1'b1;
				3'b010: ctrl.alu_to_a = 1'b1;	// MOV ALU,A
				3'b011: ctrl.acl_from_y = 1'b1;	// MOV [s],A
				default: ;
			endcase
			if (y_inc && (y_op == 3'b100 || y_op == 3'b011)) begin
				ctrl.bank[y_bank].ct_inc = 1'b1;
			end

			if (d1_op == 2'b01) begin
				ctrl.d1_src = scu_dsp_pkg::D1_IMM;
			end else if (d1_op == 2'b11) begin
				case (src_code)
					4'b0000, 4'b0001, 4'b0010, 4'b0011: ctrl.d1_src = scu_dsp_pkg::D1_MD;
					4'b0100, 4'b0101, 4'b0110, 4'b0111: begin
						ctrl.d1_src = scu_dsp_pkg::D1_MD;
						ctrl.bank[src_code[1:0]].ct_inc = 1'b1;	// MC0-MC3
					end
					4'b1001: ctrl.d1_src = scu_dsp_pkg::D1_ACL;
					4'b1010: ctrl.d1_src = scu_dsp_pkg::D1_ACH;
					default: ;
				endcase
			end

			// Both D1 moves share the destination code
			if (d1_op[0]) begin
				case (d1_dst)
					4'b0000, 4'b0001, 4'b0010, 4'b0011: begin
						ctrl.bank[d1_dst[1:0]].md_wr = 1'b1;
						ctrl.bank[d1_dst[1:0]].ct_inc = 1'b1;
					end
					4'b0100: begin
						ctrl.rx_load = 1'b1;
						ctrl.rx_from_d1 = 1'b1;	// D1 wins over X
					end
					4'b0101: ctrl.pl_from_d1 = 1'b1;
					4'b1100, 4'b1101, 4'b1110, 4'b1111: ctrl.bank[d1_dst[1:0]].ct_load = 1'b1;
					default: ;	// RA0, WA0, LOP, TOP not present
				endcase
			end
		end
	end

	// A cycle without a strobe executes as a bubble one cycle later
	bubble_no_write: assert property (@(posedge CLOCK) disable iff (rst)
		!inst_valid |=> ctrl.bank == '0 && !(ctrl.rx_load || ctrl.ry_load
		|| ctrl.pl_from_x || ctrl.pl_from_d1 || ctrl.mul_to_p
		|| ctrl.acl_from_y || ctrl.clr_a || ctrl.alu_to_a));

endmodule

//--- hw/scu_dsp_pkg.sv
package scu_dsp_pkg;

	localparam int NUM_BANKS = 4;	// MD0-MD3
	localparam int CT_W = 6;	// 64 words per bank
	localparam int WORD_W = 32;
	localparam int ACC_W = 48;	// ACH:ACL and PH:PL
	localparam int IMM_W = 8;

	// Operation command layout
	localparam int CLS_HI = 31;
	localparam int CLS_LO = 30;
	localparam int ALU_HI = 29;
	localparam int ALU_LO = 26;
	localparam int X_OP_HI = 25;
	localparam int X_OP_LO = 23;
	localparam int X_INC = 22;
	localparam int X_BANK_HI = 21;
	localparam int X_BANK_LO = 20;
	localparam int Y_OP_HI = 19;
	localparam int Y_OP_LO = 17;
	localparam int Y_INC = 16;
	localparam int Y_BANK_HI = 15;
	localparam int Y_BANK_LO = 14;
	localparam int D1_OP_HI = 13;
	localparam int D1_OP_LO = 12;
	localparam int D1_DST_HI = 11;
	localparam int D1_DST_LO = 8;
	localparam int D1_SRC_HI = 7;	// Also the immediate
	localparam int D1_SRC_LO = 0;

	localparam logic [1:0] CLS_OPERATION = 2'b00;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ACC_W-1:0] acc_t;
	typedef logic [CT_W-1:0] ct_t;
	typedef logic [$clog2(NUM_BANKS)-1:0] bank_sel_t;

	typedef enum logic [3:0] {
		ALU_NOP = 4'h0,
		ALU_AND = 4'h1,
		ALU_OR = 4'h2,
		ALU_XOR = 4'h3,
		ALU_ADD = 4'h4,
		ALU_SUB = 4'h5,
		ALU_AD2 = 4'h6,
		ALU_SR = 4'h8,
		ALU_RR = 4'h9,
		ALU_SL = 4'hA,
		ALU_RL = 4'hB,
		ALU_RL8 = 4'hF
	} alu_op_e;

	typedef enum logic [2:0] {
		D1_NONE,
		D1_IMM,
		D1_MD,	// Bank in d1_bank
		D1_ACL,
		D1_ACH
	} d1_src_e;

	typedef struct packed {
		logic ct_load;
		logic ct_inc;
		logic md_wr;
	} dsp_bank_ctrl_t;

	typedef struct packed {
		bank_sel_t x_bank;
		logic rx_load;	// Source picked by rx_from_d1
		logic pl_from_x;
		logic mul_to_p;
		bank_sel_t y_bank;
		logic ry_load;
		logic acl_from_y;
		logic clr_a;
		logic alu_to_a;
		alu_op_e alu_op;
		d1_src_e d1_src;
		bank_sel_t d1_bank;
		logic [IMM_W-1:0] imm;
		logic rx_from_d1;
		logic pl_from_d1;
		dsp_bank_ctrl_t [NUM_BANKS-1:0] bank;
	} dsp_ctrl_t;

	typedef struct packed {
		logic s;
		logic z;
		logic c;
		logic v;
	} dsp_flags_t;

endpackage

//--- hw/scu_dsp_top.sv
module scu_dsp_top (
	input logic CLOCK,
	input logic rst,
	input logic inst_valid,	// One strobe per instruction
	input scu_dsp_pkg::word_t inst,
	output scu_dsp_pkg::acc_t acc,
	output scu_dsp_pkg::acc_t prod,
	output scu_dsp_pkg::dsp_flags_t flags
);

	scu_dsp_pkg::dsp_ctrl_t ctrl;
	scu_dsp_pkg::word_t d1;	// Shared write bus into the banks
	scu_dsp_pkg::word_t md_dout [scu_dsp_pkg::NUM_BANKS];

	dsp_decoder u_decoder (
		.CLOCK(CLOCK),
		.rst(rst),
		.inst_valid(inst_valid),
		.inst(inst),
		.ctrl(ctrl)
	);

	// MD0-MD3, each with its own CT
	for (genvar i = 0; i < scu_dsp_pkg::NUM_BANKS; i++) begin : g_bank
		dsp_data_bank u_bank (
			.CLOCK(CLOCK),
			.rst(rst),
			.bank_ctrl(ctrl.bank[i]),
			.d1(d1),
			.dout(md_dout[i])
		);
	end

	dsp_datapath u_datapath (
		.CLOCK(CLOCK),
		.rst(rst),
		.ctrl(ctrl),
		.md_dout(md_dout),
		.d1(d1),
		.acc(acc),
		.prod(prod),
		.flags(flags)
	);

endmodule

//--- run_sim.sh
#!/bin/bash
# Compile with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_scu_dsp -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "All checks passed" sim.log; then
	exit 0
fi
echo "Pass line not found in sim.log"
exit 1

//--- test/tb_dsp_encode.svh
`ifndef TB_DSP_ENCODE_SVH
`define TB_DSP_ENCODE_SVH

localparam logic [3:0] NO_ALU = 4'h0;
localparam logic [2:0] X_MOV = 3'b100;	// MOV [s],X
localparam logic [2:0] X_MUL = 3'b010;
localparam logic [2:0] X_PL = 3'b011;	// MOV [s],P
localparam logic [2:0] Y_MOV = 3'b100;	// MOV [s],Y
localparam logic [2:0] Y_ACL = 3'b011;	// MOV [s],A
localparam logic [5:0] CLR_A = 6'b001000;
localparam logic [5:0] A_FROM_ALU = 6'b010000;
localparam logic [3:0] DST_RX = 4'b0100;
localparam logic [3:0] DST_PL = 4'b0101;
localparam logic [3:0] SRC_ACL = 4'b1001;
localparam logic [3:0] SRC_ACH = 4'b1010;

function automatic logic [5:0] xy_field(input logic [2:0] op, input logic inc,
		input logic [1:0] bank);
	return {op, inc, bank};
endfunction

function automatic logic [13:0] d1_imm(input logic [3:0] dst, input logic [7:0] imm);
	return {2'b01, dst, imm};
endfunction

function automatic logic [13:0] d1_move(input logic [3:0] dst, input logic [3:0] src);
	return {2'b11, dst, 4'h0, src};
endfunction

// Operation command, class 00
function automatic logic [31:0] op_word(input logic [3:0] alu, input logic [5:0] x,
		input logic [5:0] y, input logic [13:0] d1);
	return {2'b00, alu, x, y, d1};
endfunction

// Expected {s, z, c, v, new A} for one ALU op on A and P
function automatic logic [51:0] alu_ref(input logic [47:0] a, input logic [47:0] p,
		input logic [3:0] op, input logic [3:0] f);
	logic [48:0] w;
	logic [32:0] r;	// Bit 32 is the new C
	logic v;
	w = {1'b0, a} + {1'b0, p};
	v = f[0];
	case (op)
		scu_dsp_pkg::ALU_AND: r = {1'b0, a[31:0] & p[31:0]};
		scu_dsp_pkg::ALU_OR: r = {1'b0, a[31:0] | p[31:0]};
		scu_dsp_pkg::ALU_XOR: r = {1'b0, a[31:0] ^ p[31:0]};
		scu_dsp_pkg::ALU_ADD: r = {1'b0, a[31:0]} + {1'b0, p[31:0]};
		scu_dsp_pkg::ALU_SUB: r = {1'b0, a[31:0]} - {1'b0, p[31:0]};
		scu_dsp_pkg::ALU_AD2: return {w[47], (w[47:0] == 48'h0), w[48],
			((a[47] == p[47]) && (w[47] != a[47])), w[47:0]};
		scu_dsp_pkg::ALU_SR: r = {a[0], a[31], a[31:1]};
		scu_dsp_pkg::ALU_RR: r = {a[0], a[0], a[31:1]};
		scu_dsp_pkg::ALU_SL: r = {a[31:0], 1'b0};
		scu_dsp_pkg::ALU_RL: r = {a[31:0], a[31]};
		scu_dsp_pkg::ALU_RL8: r = {a[24], a[23:0], a[31:24]};
		default: return {f, a};	// NOP and spare codes
	endcase
	if (op == scu_dsp_pkg::ALU_ADD) begin
		v = (a[31] == p[31]) && (r[31] != a[31]);
	end else if (op == scu_dsp_pkg::ALU_SUB) begin
		v = (a[31] != p[31]) && (r[31] != a[31]);
	end
	return {r[31], (r[31:0] == 32'h0), r[32], v, 16'h0, r[31:0]};
endfunction

`endif

//--- test/tb_scu_dsp.sv
module tb_scu_dsp;
	timeunit 1ns;
	timeprecision 1ps;

	`include "tb_dsp_encode.svh"

	// Instructions issued by all tests, two clocks each
	localparam int INST_TOTAL = 4 * 133 + 6 * 13 + 32 * 13 + 21 + 14;
	localparam int RUN_LIMIT = (INST_TOTAL * 2 + 20) * 40 * 2;	// ns, twice the need

	logic CLOCK;
	logic rst;
	logic inst_valid;
	scu_dsp_pkg::word_t inst;
	scu_dsp_pkg::acc_t acc;
	scu_dsp_pkg::acc_t prod;
	scu_dsp_pkg::dsp_flags_t flags;

	int errors;
	int checks;
	logic [31:0] lcg_state;
	logic [47:0] exp_a;	// Expected A
	logic [47:0] exp_p;
	logic [3:0] exp_f;
	logic [31:0] prog [$];

	scu_dsp_top i_dut (
		.CLOCK(CLOCK),
		.rst(rst),
		.inst_valid(inst_valid),
		.inst(inst),
		.acc(acc),
		.prod(prod),
		.flags(flags)
	);

	initial begin
		CLOCK = 1'b0;
		forever begin
			#20 CLOCK = ~CLOCK;
		end
	end

	initial begin
		#(RUN_LIMIT);
		$display("Timeout after %0d ns, %0d errors so far", RUN_LIMIT, errors);
		$display("Checks failed");
		$finish;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic compare_value(input string name, input logic [47:0] expected,
			input logic [47:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Strobe one word and return once it has executed
	task automatic issue(input logic [31:0] word);
		inst_valid = 1'b1;
		inst = word;
		@(negedge CLOCK);
		inst_valid = 1'b0;
		inst = '0;
		@(negedge CLOCK);
	endtask

	task automatic ct_zero(input int b);
		issue(op_word(NO_ALU, '0, '0, d1_imm({2'b11, b[1:0]}, 8'h00)));
	endtask

	// ACL to word 0 of bank b, A cleared in the same word
	task automatic store_acl(input int b);
		ct_zero(b);
		issue(op_word(NO_ALU, '0, CLR_A, d1_move({2'b00, b[1:0]}, SRC_ACL)));
		exp_a = '0;
	endtask

	task automatic alu_step(input logic [3:0] op, input logic pl_load, input logic [7:0] imm);
		logic [51:0] r;
		r = alu_ref(exp_a, exp_p, op, exp_f);	// ALU sees PL before this word loads it
		issue(op_word(op, '0, A_FROM_ALU, pl_load ? d1_imm(DST_PL, imm) : 14'h0));
		exp_f = r[51:48];
		exp_a = r[47:0];
		if (pl_load) begin
			exp_p = {40'h0, imm};
		end
	endtask

	// Bytes go in through PL, joined by OR and RL8
	task automatic build_acl(input logic [31:0] value);
		issue(op_word(NO_ALU, '0, CLR_A, d1_imm(DST_PL, value[31:24])));
		exp_a = '0;
		exp_p = {40'h0, value[31:24]};
		alu_step(scu_dsp_pkg::ALU_OR, 1'b0, 8'h00);
		for (int i = 2; i >= 0; i--) begin
			alu_step(scu_dsp_pkg::ALU_RL8, 1'b1, value[i*8 +: 8]);
			alu_step(scu_dsp_pkg::ALU_OR, 1'b0, 8'h00);
		end
		compare_value("build acl", {16'h0, value}, acc);
	endtask

	task automatic multiply(input logic [7:0] rx_imm, input logic [31:0] ry_val, input int b);
		logic [63:0] full;
		build_acl(ry_val);
		store_acl(b);
		ct_zero(b);
		issue(op_word(NO_ALU, '0, xy_field(Y_MOV, 1'b0, b[1:0]), d1_imm(DST_RX, rx_imm)));
		issue(op_word(NO_ALU, xy_field(X_MUL, 1'b0, 2'd0), '0, '0));
		full = {56'h0, rx_imm} * {{32{ry_val[31]}}, ry_val};
		exp_p = full[47:0];
		compare_value("multiply", exp_p, prod);
	endtask

	task automatic test_reset();
		compare_value("reset acc", 48'h0, acc);
		compare_value("reset prod", 48'h0, prod);
		compare_value("reset flags", 48'h0, {44'h0, flags});
	endtask

	task automatic test_counters();
		logic [7:0] md_model [4][64];
		logic [7:0] v;
		for (int b = 0; b < 4; b++) begin
			for (int i = 0; i < 66; i++) begin	// Last two wrap onto words 0 and 1
				v = 8'(lcg_next());
				issue(op_word(NO_ALU, '0, '0, d1_imm({2'b00, b[1:0]}, v)));
				md_model[b][i % 64] = v;
			end
			// CT load and MC increment together, the load must win
			issue(op_word(NO_ALU, xy_field(X_MOV, 1'b1, b[1:0]), '0,
				d1_imm({2'b11, b[1:0]}, 8'h00)));
			for (int i = 0; i < 66; i++) begin
				issue(op_word(NO_ALU, '0, '0, d1_move(DST_PL, {2'b01, b[1:0]})));
				compare_value($sformatf("md%0d read %0d", b, i),
					{40'h0, md_model[b][i % 64]}, prod);
			end
		end
	endtask

	task automatic test_multiplier();
		logic [31:0] value;
		for (int n = 0; n < 6; n++) begin
			value = lcg_next();
			value[31] = n[0];	// Odd rounds give a negative RY
			multiply(8'(lcg_next()), value, n % 4);
		end
	endtask

	task automatic test_alu();
		logic [31:0] value;
		logic [7:0] imm;
		for (int k = 0; k < 16; k++) begin
			for (int n = 0; n < 2; n++) begin
				value = lcg_next();
				imm = 8'(lcg_next());
				build_acl(value);
				store_acl(0);
				ct_zero(0);
				issue(op_word(NO_ALU, '0, xy_field(Y_ACL, 1'b0, 2'd0), d1_imm(DST_PL, imm)));
				exp_a = {16'h0, value};
				exp_p = {40'h0, imm};
				alu_step(4'(k), 1'b0, 8'h00);
				compare_value($sformatf("alu op %0h acc", k), exp_a, acc);
				compare_value($sformatf("alu op %0h flags", k), {44'h0, exp_f}, {44'h0, flags});
			end
		end
	endtask

	task automatic test_acc_moves();
		multiply(8'(lcg_next()) | 8'h80, (lcg_next() & 32'h7fff_ffff) | 32'h4000_0000, 2);
		alu_step(scu_dsp_pkg::ALU_AD2, 1'b0, 8'h00);	// A = P, ACH nonzero
		compare_value("ad2 acc", exp_a, acc);
		ct_zero(3);
		issue(op_word(NO_ALU, '0, '0, d1_move(4'b0011, SRC_ACL)));
		issue(op_word(NO_ALU, '0, '0, d1_move(4'b0011, SRC_ACH)));
		issue(op_word(NO_ALU, '0, CLR_A, '0));
		compare_value("clr a", 48'h0, acc);
		ct_zero(3);
		issue(op_word(NO_ALU, xy_field(X_PL, 1'b1, 2'd3), '0, '0));
		compare_value("acl via pl", {16'h0, exp_a[31:0]}, prod);
		issue(op_word(NO_ALU, xy_field(X_PL, 1'b1, 2'd3), '0, '0));
		compare_value("ach via pl", {32'h0, exp_a[47:32]}, prod);
	endtask

	task automatic test_back_to_back();
		logic [7:0] i0;
		logic [7:0] i1;
		logic [47:0] prog_acc;
		logic [47:0] prog_prod;
		i0 = 8'(lcg_next());
		i1 = 8'(lcg_next());
		prog = {};
		prog.push_back(op_word(NO_ALU, '0, CLR_A, d1_imm(4'b1101, 8'h00)));
		prog.push_back(op_word(NO_ALU, '0, '0, d1_imm(DST_PL, i0)));
		prog.push_back(op_word(scu_dsp_pkg::ALU_ADD, '0, A_FROM_ALU, d1_imm(DST_RX, i1)));
		prog.push_back(op_word(scu_dsp_pkg::ALU_SL, '0, A_FROM_ALU,
			d1_move(4'b0001, SRC_ACL)));	// MD1 gets the sum
		prog.push_back(op_word(NO_ALU, '0, '0, d1_imm(4'b1101, 8'h00)));
		prog.push_back(op_word(scu_dsp_pkg::ALU_ADD, '0, xy_field(Y_MOV, 1'b0, 2'd1),
			d1_imm(DST_PL, 8'h5a)));
		prog.push_back(op_word(scu_dsp_pkg::ALU_ADD, xy_field(X_MUL, 1'b0, 2'd0),
			A_FROM_ALU, '0));
		prog_acc = {40'h0, i0} * 48'd2 + 48'h5a;	// Sum shifted left once, then plus PL
		prog_prod = {40'h0, i0} * {40'h0, i1};
		foreach (prog[k]) begin
			issue(prog[k]);
		end
		compare_value("idle acc", prog_acc, acc);
		compare_value("idle prod", prog_prod, prod);
		foreach (prog[k]) begin
			inst_valid = 1'b1;
			inst = prog[k];
			@(negedge CLOCK);
		end
		inst_valid = 1'b0;
		inst = '0;
		@(negedge CLOCK);
		compare_value("burst acc", prog_acc, acc);
		compare_value("burst prod", prog_prod, prod);
	endtask

	initial begin
		errors = 0;
		checks = 0;
		lcg_state = 32'h0fc4d02f;
		exp_a = '0;
		exp_p = '0;
		exp_f = '0;
		rst = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		repeat (3) @(negedge CLOCK);
		rst = 1'b0;
		test_reset();
		test_counters();
		test_multiplier();
		test_alu();
		test_acc_moves();
		test_back_to_back();
		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
